//--- exu_top.f
verilog/alu_pkg.sv
verilog/exu_pkg.sv
verilog/exu_decode.sv
verilog/op_fifo.sv
verilog/alu_int.sv
verilog/mul_div_seq.sv
verilog/exu_execute.sv
verilog/exu_top.sv
testbench/exu_chk.sv
testbench/exu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= exu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/exu_tb.sv
`default_nettype none

module exu_tb;
  import exu_pkg::*;

  localparam logic [63:0] ONES = '1;
  localparam logic [63:0] MIN  = 64'h8000_0000_0000_0000;

  // request mode bits are alt, muldiv, word, lui
  localparam logic [3:0] ALU  = 4'b0000;
  localparam logic [3:0] ALT  = 4'b1000;
  localparam logic [3:0] MD   = 4'b0100;
  localparam logic [3:0] W    = 4'b0010;
  localparam logic [3:0] WALT = 4'b1010;
  localparam logic [3:0] LUI  = 4'b0001;

  // operand source and back-pressure flags
  localparam logic [1:0] FIX    = 2'b00;
  localparam logic [1:0] RND    = 2'b10;
  localparam logic [1:0] RND_BP = 2'b11;

  typedef struct packed {
    exu_req_t req;
    logic     bp;
  } stim_t;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  logic        req_ready;
  exu_req_t    req;
  logic        rsp_valid;
  logic        rsp_ready;
  exu_rsp_t    rsp;
  int          cycle = 0;
  int          limit = 0;
  int          n_rcv = 0;
  logic [63:0] rng_state = 64'd4743;
  stim_t       stim_q[$];
  exu_rsp_t    exp_q[$];

  exu_top #(
    .FIFO_DEPTH (4)
  ) i_exu_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (limit > 0 && cycle >= limit) begin
      fail_run($sformatf("timeout: run went past %0d cycles", limit));
    end else if (i_exu_top.i_exu_chk.violations != 0) begin
      fail_run("a handshake assertion fired");
    end
  end

  function automatic logic [63:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  // RISC-V integer and M-extension rules
  function automatic exu_rsp_t expected_result(input exu_req_t r);
    logic [63:0]        a;
    logic [63:0]        b;
    logic [5:0]         sh;
    logic [127:0]       p_ss;
    logic [127:0]       p_su;
    logic [127:0]       p_uu;
    logic signed [63:0] sq;
    logic signed [63:0] sr;
    logic signed [63:0] sra64;
    logic signed [31:0] sra32;
    logic [31:0]        w;
    logic               ovf;
    exu_rsp_t           e;
    a     = r.src1;
    b     = r.src2;
    sh    = r.word ? {1'b0, b[4:0]} : b[5:0];
    p_ss  = {{64{a[63]}}, a} * {{64{b[63]}}, b};
    p_su  = {{64{a[63]}}, a} * {64'd0, b};
    p_uu  = {64'd0, a} * {64'd0, b};
    ovf   = (a == MIN) && (b == ONES);
    sq    = '0;
    sr    = '0;
    if (b != '0 && !ovf) begin
      sq = $signed(a) / $signed(b);
      sr = $signed(a) % $signed(b);
    end
    sra64 = $signed(a) >>> sh;
    sra32 = $signed(a[31:0]) >>> sh;
    w     = '0;
    e     = '0;
    if (r.lui) begin
      e.result = b;
    end else if (r.muldiv) begin
      case (r.funct3)
        3'd0:    e.result = p_uu[63:0];
        3'd1:    e.result = p_ss[127:64];
        3'd2:    e.result = p_su[127:64];
        3'd3:    e.result = p_uu[127:64];
        3'd4:    e.result = (b == '0) ? ONES : (ovf ? MIN : sq);
        3'd5:    e.result = (b == '0) ? ONES : a / b;
        3'd6:    e.result = (b == '0) ? a : sr;
        default: e.result = (b == '0) ? a : a % b;
      endcase
    end else if (r.word) begin
      // OP-32 only has add, sub and the shifts
      case (r.funct3)
        3'd0:    w = r.alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
        3'd1:    w = a[31:0] << sh;
        default: w = r.alt ? sra32 : a[31:0] >> sh;
      endcase
      e.result = {{32{w[31]}}, w};
    end else begin
      case (r.funct3)
        3'd0:    e.result = r.alt ? a - b : a + b;
        3'd1:    e.result = a << sh;
        3'd2:    e.result = {63'd0, $signed(a) < $signed(b)};
        3'd3:    e.result = {63'd0, a < b};
        3'd4:    e.result = a ^ b;
        3'd5:    e.result = r.alt ? sra64 : a >> sh;
        3'd6:    e.result = a | b;
        default: e.result = a & b;
      endcase
    end
    return e;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic check_rsp(input exu_rsp_t act, input exu_rsp_t exp);
    if (act !== exp) begin
      fail_run($sformatf("CHECK FAILED at time %0t: rsp.result expected %h actual %h",
                         $time, exp.result, act.result));
    end
  endtask

  task automatic check_handshake(input exu_rsp_t held, input exu_rsp_t now,
                                 input logic valid);
    if (!valid) begin
      fail_run("rsp_valid dropped before the held response was taken");
    end
    if (now !== held) begin
      fail_run($sformatf("CHECK FAILED at time %0t: held rsp.result expected %h actual %h",
                         $time, held.result, now.result));
    end
  endtask

  task automatic check_latency(input int act, input int exp);
    if (act != exp) begin
      fail_run($sformatf("CHECK FAILED at time %0t: rsp latency expected %0d actual %0d",
                         $time, exp, act));
    end
  endtask

  task automatic add_entry(input logic [2:0] f3, input logic [3:0] mode,
                           input logic [63:0] s1, input logic [63:0] s2,
                           input logic [1:0] flags);
    stim_t s;
    s = '0;
    s.req.funct3 = f3;
    {s.req.alt, s.req.muldiv, s.req.word, s.req.lui} = mode;
    s.req.src1 = flags[1] ? next_random() : s1;
    s.req.src2 = flags[1] ? next_random() : s2;
    s.bp = flags[0];
    stim_q.push_back(s);
  endtask

  task automatic build_table();
    // ALU corners
    add_entry(3'd0, ALU, ONES, 64'd1, FIX);
    add_entry(3'd0, ALU, MIN, ONES, FIX);
    add_entry(3'd0, ALT, 64'd0, 64'd1, FIX);
    add_entry(3'd0, ALT, MIN, 64'd1, FIX);
    add_entry(3'd1, ALU, ONES, 64'd0, FIX);
    add_entry(3'd1, ALU, 64'd1, 64'd31, FIX);
    add_entry(3'd1, ALU, 64'd1, 64'd32, FIX);
    add_entry(3'd1, ALU, ONES, 64'd63, FIX);
    add_entry(3'd1, ALU, 64'd1, 64'hffff_ffff_ffff_ffc1, FIX);
    add_entry(3'd2, ALU, MIN, 64'd0, FIX);
    add_entry(3'd2, ALU, 64'd0, ONES, FIX);
    add_entry(3'd2, ALU, ONES, ONES, FIX);
    add_entry(3'd2, ALU, MIN, 64'd1, FIX);
    add_entry(3'd3, ALU, 64'd0, ONES, FIX);
    add_entry(3'd3, ALU, ONES, 64'd0, FIX);
    add_entry(3'd4, ALU, ONES, 64'h0123_4567_89ab_cdef, FIX);
    add_entry(3'd5, ALU, MIN, 64'd63, FIX);
    add_entry(3'd5, ALU, ONES, 64'd32, FIX);
    add_entry(3'd5, ALT, MIN, 64'd31, FIX);
    add_entry(3'd5, ALT, MIN, 64'd63, FIX);
    add_entry(3'd5, ALT, MIN, 64'd0, FIX);
    add_entry(3'd6, ALU, MIN, 64'd1, FIX);
    add_entry(3'd7, ALU, ONES, 64'h5555_0000_aaaa_ffff, FIX);
    add_entry(3'd0, LUI, ONES, 64'hffff_ffff_8000_0000, FIX);
    // word forms crossing bit 31
    add_entry(3'd0, W, 64'h7fff_ffff, 64'd1, FIX);
    add_entry(3'd0, W, 64'h1_ffff_ffff, 64'd1, FIX);
    add_entry(3'd0, WALT, 64'd0, 64'h8000_0000, FIX);
    add_entry(3'd1, W, 64'd1, 64'd31, FIX);
    add_entry(3'd1, W, 64'd3, 64'd63, FIX);
    add_entry(3'd5, W, 64'hffff_ffff_8000_0000, 64'd0, FIX);
    add_entry(3'd5, W, 64'hffff_ffff_8000_0000, 64'd31, FIX);
    add_entry(3'd5, WALT, 64'h8000_0000, 64'd31, FIX);
    add_entry(3'd5, WALT, 64'h1_4000_0000, 64'd32, FIX);
    // multiply
    add_entry(3'd0, MD, ONES, ONES, FIX);
    add_entry(3'd1, MD, MIN, MIN, FIX);
    add_entry(3'd1, MD, MIN, ONES, FIX);
    add_entry(3'd2, MD, ONES, ONES, FIX);
    add_entry(3'd3, MD, ONES, ONES, FIX);
    add_entry(3'd0, MD, 64'd0, 64'd0, RND);
    add_entry(3'd1, MD, 64'd0, 64'd0, RND);
    add_entry(3'd2, MD, 64'd0, 64'd0, RND);
    add_entry(3'd3, MD, 64'd0, 64'd0, RND);
    // divide and remainder with zero divisor and overflow
    add_entry(3'd4, MD, 64'd7, 64'd0, FIX);
    add_entry(3'd5, MD, 64'd7, 64'd0, FIX);
    add_entry(3'd6, MD, 64'hffff_ffff_ffff_fff9, 64'd0, FIX);
    add_entry(3'd7, MD, 64'd7, 64'd0, FIX);
    add_entry(3'd4, MD, MIN, ONES, FIX);
    add_entry(3'd6, MD, MIN, ONES, FIX);
    add_entry(3'd4, MD, 64'hffff_ffff_ffff_fff9, 64'd2, FIX);
    add_entry(3'd6, MD, 64'hffff_ffff_ffff_fff9, 64'd2, FIX);
    add_entry(3'd5, MD, ONES, 64'd3, FIX);
    add_entry(3'd7, MD, ONES, 64'd3, FIX);
    add_entry(3'd4, MD, 64'd0, 64'd0, RND);
    add_entry(3'd5, MD, 64'd0, 64'd0, RND);
    add_entry(3'd6, MD, 64'd0, 64'd0, RND);
    add_entry(3'd7, MD, 64'd0, 64'd0, RND);
    // mixed traffic under random rsp_ready
    add_entry(3'd0, ALU, 64'd0, 64'd0, RND_BP);
    add_entry(3'd0, MD, 64'd0, 64'd0, RND_BP);
    add_entry(3'd5, WALT, 64'd0, 64'd0, RND_BP);
    add_entry(3'd2, ALU, 64'd0, 64'd0, RND_BP);
    add_entry(3'd4, MD, 64'd0, 64'd0, RND_BP);
    add_entry(3'd4, ALU, 64'd0, 64'd0, RND_BP);
    add_entry(3'd1, W, 64'd0, 64'd0, RND_BP);
    add_entry(3'd7, MD, 64'd0, 64'd0, RND_BP);
    add_entry(3'd6, ALU, 64'd0, 64'd0, RND_BP);
    add_entry(3'd0, ALT, 64'd0, 64'd0, RND_BP);
  endtask

  // returns just after the accepting edge so the next item can be driven
  task automatic wait_accept();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = req_ready;
      @(posedge clk);
    end
    #10;
  endtask

  task automatic send_all();
    foreach (stim_q[i]) begin
      req       = stim_q[i].req;
      req_valid = 1'b1;
      wait_accept();
      exp_q.push_back(expected_result(stim_q[i].req));
    end
    req_valid = 1'b0;
    req       = '0;
  endtask

  task automatic receive_all();
    exu_rsp_t    held;
    logic        holding;
    logic [63:0] rnd;
    held    = '0;
    holding = 1'b0;
    while (n_rcv < stim_q.size()) begin
      @(posedge clk);
      #10;
      if (stim_q[n_rcv].bp) begin
        rnd       = next_random();
        rsp_ready = rnd[0];
      end else begin
        rsp_ready = 1'b1;
      end
      @(negedge clk);
      if (holding) begin
        check_handshake(held, rsp, rsp_valid);
      end
      holding = rsp_valid && !rsp_ready;
      held    = rsp;
      if (rsp_valid && rsp_ready) begin
        if (exp_q.size() == 0) begin
          fail_run("a response came out with no request outstanding");
        end
        check_rsp(rsp, exp_q.pop_front());
        n_rcv++;
      end
    end
  endtask

  task automatic measure_latency();
    exu_req_t r;
    int       t_acc;
    @(posedge clk);
    #10;
    rsp_ready = 1'b1;
    @(negedge clk);
    if (rsp_valid) begin
      fail_run("rsp_valid still high after the last expected response");
    end
    @(posedge clk);
    #10;
    r         = '0;
    r.src1    = 64'd40;
    r.src2    = 64'd2;
    req       = r;
    req_valid = 1'b1;
    wait_accept();
    t_acc     = cycle;
    req_valid = 1'b0;
    do begin
      @(negedge clk);
    end while (!rsp_valid);
    check_latency(cycle - t_acc, 2);
    check_rsp(rsp, expected_result(r));
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b1;
    build_table();
    limit = (stim_q.size() + 1) * 80 + 200;
    repeat (10) @(posedge clk);
    #10;
    rst_n = 1'b1;
    if (!req_ready || rsp_valid) begin
      fail_run("handshake outputs are not idle after reset");
    end
    fork
      send_all();
      receive_all();
    join
    measure_latency();
    if (n_rcv == stim_q.size() && exp_q.size() == 0 &&
        i_exu_top.i_exu_chk.violations == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      fail_run("responses missing or a handshake assertion fired");
    end
  end

endmodule

`default_nettype wire

//--- testbench/exu_chk.sv
`default_nettype none

module exu_chk (
  input logic              clk,
  input logic              rst_n,
  input logic              req_valid,
  input logic              req_ready,
  input exu_pkg::exu_req_t req,
  input logic              rsp_valid,
  input logic              rsp_ready,
  input exu_pkg::exu_rsp_t rsp
);
  int violations = 0;

  // a stalled request stays put until taken
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && !req_ready |=> req_valid && $stable(req))
    else begin
      violations++;
      $error("request dropped or changed while req_ready was low");
    end

  // same for the held result
  rsp_held: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else begin
      violations++;
      $error("response dropped or changed while rsp_ready was low");
    end

  rsp_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !rsp_valid)
    else begin
      violations++;
      $error("rsp_valid high during reset");
    end

endmodule

bind exu_top exu_chk i_exu_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .req_valid (req_valid),
  .req_ready (req_ready),
  .req       (req),
  .rsp_valid (rsp_valid),
  .rsp_ready (rsp_ready),
  .rsp       (rsp)
);

`default_nettype wire

//--- verilog/exu_top.sv
`default_nettype none

module exu_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid,
  output logic              req_ready,
  input  exu_pkg::exu_req_t req,
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output exu_pkg::exu_rsp_t rsp
);
  import exu_pkg::*;

  logic    dec_valid;
  logic    dec_ready;
  exu_op_t dec_op;
  logic    fifo_valid;
  logic    fifo_ready;
  exu_op_t fifo_op;

  exu_decode i_exu_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec_op    (dec_op)
  );

  op_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .payload_t  (exu_op_t)
  ) i_op_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (dec_valid),
    .in_ready  (dec_ready),
    .in_data   (dec_op),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready),
    .out_data  (fifo_op)
  );

  exu_execute i_exu_execute (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_valid  (fifo_valid),
    .op_ready  (fifo_ready),
    .op        (fifo_op),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

endmodule

`default_nettype wire

//--- verilog/exu_execute.sv
`default_nettype none

module exu_execute (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              op_valid,
  output logic              op_ready,
  input  exu_pkg::exu_op_t  op,
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output exu_pkg::exu_rsp_t rsp
);
  import alu_pkg::*;
  import exu_pkg::*;

  logic            busy;
  logic            pop;
  logic            alu_pop;
  logic            md_start;
  logic            md_done;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] md_result;

  // stall while iterating or while a result waits to be taken
  assign op_ready = !busy && (!rsp_valid || rsp_ready);
  assign pop      = op_valid && op_ready;
  assign alu_pop  = pop && (op.unit == UNIT_ALU);
  assign md_start = pop && (op.unit == UNIT_MULDIV);

  alu_int i_alu_int (
    .op     (op.op),
    .word   (op.word),
    .src1   (op.src1),
    .src2   (op.src2),
    .result (alu_result)
  );

  mul_div_seq i_mul_div_seq (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (md_start),
    .op     (op.op),
    .src1   (op.src1),
    .src2   (op.src2),
    .done   (md_done),
    .result (md_result)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      if (md_start) begin
        busy <= 1'b1;
      end else if (md_done) begin
        busy <= 1'b0;
      end
      if (alu_pop || md_done) begin
        rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alu_pop) begin
      rsp.result <= alu_result;
    end else if (md_done) begin
      rsp.result <= md_result;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mul_div_seq.sv
`default_nettype none

module mul_div_seq (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  alu_pkg::alu_op_e         op,
  input  logic [exu_pkg::XLEN-1:0] src1,
  input  logic [exu_pkg::XLEN-1:0] src2,
  output logic                     done,
  output logic [exu_pkg::XLEN-1:0] result
);
  import alu_pkg::*;
  import exu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_FIX
  } state_e;

  state_e            state;
  logic [5:0]        step;
  alu_op_e           op_q;
  logic              neg_q;
  logic [XLEN-1:0]   hi;
  logic [XLEN-1:0]   lo;
  logic [XLEN-1:0]   b_q;
  logic              is_div;
  logic              is_rem;
  logic              a_neg;
  logic              b_neg;
  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;
  logic              div_zero;
  logic              div_ovf;
  logic              is_mul_q;
  logic [XLEN:0]     mul_sum;
  logic [XLEN:0]     div_shift;
  logic [XLEN:0]     div_diff;
  logic              div_fits;
  logic [2*XLEN-1:0] product;
  logic [XLEN-1:0]   quotient;
  logic [XLEN-1:0]   remainder;

  assign is_div   = op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  assign is_rem   = op inside {OP_REM, OP_REMU};
  assign a_neg    = (op inside {OP_MULH, OP_MULHSU, OP_DIV, OP_REM}) && src1[XLEN-1];
  assign b_neg    = (op inside {OP_MULH, OP_DIV, OP_REM}) && src2[XLEN-1];
  assign a_mag    = a_neg ? -src1 : src1;
  assign b_mag    = b_neg ? -src2 : src2;
  assign div_zero = is_div && (src2 == '0);
  assign div_ovf  = (op inside {OP_DIV, OP_REM}) && (&src2) &&
                    (src1 == {1'b1, {(XLEN-1){1'b0}}});

  // one radix-2 step per cycle
  assign is_mul_q  = op_q inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  assign mul_sum   = {1'b0, hi} + (lo[0] ? {1'b0, b_q} : {(XLEN+1){1'b0}});
  assign div_shift = {hi, lo[XLEN-1]};
  assign div_fits  = div_shift >= {1'b0, b_q};
  assign div_diff  = div_shift - {1'b0, b_q};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      step  <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            step  <= '0;
            // corner cases skip the iterations
            state <= (div_zero || div_ovf) ? ST_FIX : ST_RUN;
          end
        end
        ST_RUN: begin
          step <= step + 6'd1;
          if (step == 6'd63) begin
            state <= ST_FIX;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      op_q <= op;
      b_q  <= b_mag;
      if (div_zero) begin
        hi    <= src1;
        lo    <= '1;
        neg_q <= 1'b0;
      end else if (div_ovf) begin
        hi    <= '0;
        lo    <= src1;
        neg_q <= 1'b0;
      end else begin
        hi    <= '0;
        lo    <= a_mag;
        // remainder takes the dividend sign
        neg_q <= is_rem ? a_neg : (a_neg ^ b_neg);
      end
    end else if (state == ST_RUN) begin
      if (is_mul_q) begin
        hi <= mul_sum[XLEN:1];
        lo <= {mul_sum[0], lo[XLEN-1:1]};
      end else if (div_fits) begin
        hi <= div_diff[XLEN-1:0];
        lo <= {lo[XLEN-2:0], 1'b1};
      end else begin
        hi <= div_shift[XLEN-1:0];
        lo <= {lo[XLEN-2:0], 1'b0};
      end
    end
  end

  assign product   = neg_q ? -{hi, lo} : {hi, lo};
  assign quotient  = neg_q ? -lo : lo;
  assign remainder = neg_q ? -hi : hi;

  always_comb begin
    case (op_q)
      OP_MUL:    result = product[XLEN-1:0];
      OP_MULH,
      OP_MULHSU,
      OP_MULHU:  result = product[2*XLEN-1:XLEN];
      OP_DIV,
      OP_DIVU:   result = quotient;
      OP_REM,
      OP_REMU:   result = remainder;
      default:   result = '0;
    endcase
  end

  assign done = (state == ST_FIX);

endmodule

`default_nettype wire

//--- verilog/alu_int.sv
`default_nettype none

module alu_int (
  input  alu_pkg::alu_op_e         op,
  input  logic                     word,
  input  logic [exu_pkg::XLEN-1:0] src1,
  input  logic [exu_pkg::XLEN-1:0] src2,
  output logic [exu_pkg::XLEN-1:0] result
);
  import alu_pkg::*;
  import exu_pkg::*;

  logic            subtract;
  logic [XLEN-1:0] addend;
  logic [XLEN-1:0] sum;
  logic            carry;
  logic            overflow;
  logic            less;
  logic [5:0]      shamt;
  logic [XLEN-1:0] shift_src;
  logic [XLEN-1:0] raw;
  logic            word_op;

  // one adder where subtract inverts src2 and sets carry in
  assign subtract = (op == OP_SUB) || (op == OP_SLT) || (op == OP_SLTU);
  assign addend   = src2 ^ {XLEN{subtract}};
  assign {carry, sum} = {1'b0, src1} + {1'b0, addend} + {{XLEN{1'b0}}, subtract};
  assign overflow = (src1[XLEN-1] == addend[XLEN-1]) && (sum[XLEN-1] != src1[XLEN-1]);

  // unsigned less when no carry out of the subtraction
  assign less = (op == OP_SLTU) ? !carry : (sum[XLEN-1] ^ overflow);

  assign shamt = word ? {1'b0, src2[4:0]} : src2[5:0];

  // word right shifts see only the low half
  always_comb begin
    if (!word) begin
      shift_src = src1;
    end else if (op == OP_SRA) begin
      shift_src = {{(XLEN-32){src1[31]}}, src1[31:0]};
    end else begin
      shift_src = {{(XLEN-32){1'b0}}, src1[31:0]};
    end
  end

  always_comb begin
    case (op)
      OP_ADD,
      OP_SUB:  raw = sum;
      OP_SLL:  raw = src1 << shamt;
      OP_SLT,
      OP_SLTU: raw = {{(XLEN-1){1'b0}}, less};
      OP_XOR:  raw = src1 ^ src2;
      OP_SRL:  raw = shift_src >> shamt;
      OP_SRA:  raw = $signed(shift_src) >>> shamt;
      OP_OR:   raw = src1 | src2;
      OP_AND:  raw = src1 & src2;
      OP_PASS: raw = src2;
      default: raw = '0;
    endcase
  end

  assign word_op = word && (op inside {OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA});

  // OP-32 results are sign extended from bit 31
  assign result = word_op ? {{(XLEN-32){raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

//--- verilog/op_fifo.sv
`default_nettype none

module op_fifo #(
  parameter int  FIFO_DEPTH = 4,
  parameter type payload_t  = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);
  localparam int PTR_W = $clog2(FIFO_DEPTH);

  payload_t         mem [FIFO_DEPTH];
  logic [PTR_W:0]   wr_ptr;
  logic [PTR_W:0]   rd_ptr;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  // extra msb tells a full ring from an empty one
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                 (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

  assign in_ready  = !full;
  assign out_valid = !empty;
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign out_data  = mem[rd_ptr[PTR_W-1:0]];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[PTR_W-1:0]] <= in_data;
    end
  end

endmodule

`default_nettype wire

//--- verilog/exu_decode.sv
`default_nettype none

module exu_decode (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid,
  output logic              req_ready,
  input  exu_pkg::exu_req_t req,
  output logic              dec_valid,
  input  logic              dec_ready,
  output exu_pkg::exu_op_t  dec_op
);
  import alu_pkg::*;
  import exu_pkg::*;

  exu_op_t decoded;

  always_comb begin
    decoded.src1 = req.src1;
    decoded.src2 = req.src2;
    decoded.word = req.word && !req.muldiv && !req.lui;
    decoded.unit = UNIT_ALU;
    decoded.op   = OP_ADD;
    if (req.lui) begin
      decoded.op = OP_PASS;
    end else if (req.muldiv) begin
      decoded.unit = UNIT_MULDIV;
      decoded.op   = alu_op_e'({2'b10, req.funct3});
    end else begin
      case (req.funct3)
        3'b000:  decoded.op = req.alt ? OP_SUB : OP_ADD;
        3'b001:  decoded.op = OP_SLL;
        3'b010:  decoded.op = OP_SLT;
        3'b011:  decoded.op = OP_SLTU;
        3'b100:  decoded.op = OP_XOR;
        3'b101:  decoded.op = req.alt ? OP_SRA : OP_SRL;
        3'b110:  decoded.op = OP_OR;
        default: decoded.op = OP_AND;
      endcase
    end
  end

  // single entry that refills in the cycle it drains
  assign req_ready = !dec_valid || dec_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else if (req_valid && req_ready) begin
      dec_valid <= 1'b1;
    end else if (dec_ready) begin
      dec_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      dec_op <= decoded;
    end
  end

endmodule

`default_nettype wire

//--- verilog/exu_pkg.sv
`default_nettype none

package exu_pkg;

  localparam int XLEN = 64;

  // raw request as it arrives from the issue side
  typedef struct packed {
    logic [2:0]      funct3;
    logic            alt;
    logic            muldiv;
    logic            word;
    logic            lui;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
  } exu_req_t;

  // decoded operation without any function fields
  typedef struct packed {
    alu_pkg::alu_op_e op;
    alu_pkg::unit_e   unit;
    logic             word;
    logic [XLEN-1:0]  src1;
    logic [XLEN-1:0]  src2;
  } exu_op_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
  } exu_rsp_t;

endpackage

`default_nettype wire

//--- verilog/alu_pkg.sv
`default_nettype none

package alu_pkg;

  // bit 4 marks multiply/divide, whose low bits follow funct3
  typedef enum logic [4:0] {
    OP_ADD    = 5'h00,
    OP_SUB    = 5'h01,
    OP_SLL    = 5'h02,
    OP_SLT    = 5'h03,
    OP_SLTU   = 5'h04,
    OP_XOR    = 5'h05,
    OP_SRL    = 5'h06,
    OP_SRA    = 5'h07,
    OP_OR     = 5'h08,
    OP_AND    = 5'h09,
    OP_PASS   = 5'h0a,
    OP_MUL    = 5'h10,
    OP_MULH   = 5'h11,
    OP_MULHSU = 5'h12,
    OP_MULHU  = 5'h13,
    OP_DIV    = 5'h14,
    OP_DIVU   = 5'h15,
    OP_REM    = 5'h16,
    OP_REMU   = 5'h17
  } alu_op_e;

  typedef enum logic {
    UNIT_ALU    = 1'b0,
    UNIT_MULDIV = 1'b1
  } unit_e;

endpackage

`default_nettype wire
